// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFormat;

	typedef union packed {
		rFormat rFields;
		iFormat iFields;
	} instrWord;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOp;

	typedef enum logic [1:0] {
		none,
		fromMem,
		fromWb
	} fwdSel;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		instrWord instr;
	} ifIdReg;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dest;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] imm;
		aluOp alu;
		logic aluSrcImm;
		logic memRead;
		logic memWrite;
		logic regWrite;
	} idExReg;

	typedef struct packed {
		logic [4:0] dest;
		logic [31:0] aluRes;
		logic [31:0] storeData;
		logic memRead;
		logic memWrite;
		logic regWrite;
	} exMemReg;

	typedef struct packed {
		logic [4:0] dest;
		logic [31:0] wrData;
		logic regWrite;
	} memWbReg;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [31:0] datW;
		logic [3:0] sel;
	} wbMaster;

	typedef struct packed {
		logic ack;
		logic [31:0] datR;
	} wbSlave;

	typedef struct packed {
		logic valid;
		logic [4:0] idx;
		logic [31:0] data;
	} retireInfo;

endpackage

`default_nettype wire

// ==== fetchUnit.sv ====
`default_nettype none

module fetchUnit (
	input wire clk,
	input wire rst_sign,
	input wire pcWr,
	input wire ifIdWr,
	input wire branchTaken,
	input wire [31:0] branchTarget,
	output mipsPkg::wbMaster iBusOut,
	input wire mipsPkg::wbSlave iBusIn,
	output mipsPkg::ifIdReg ifId,
	output logic fetchWait
);

	logic [31:0] pc;
	logic active; // Low only in the cycle right after reset
	logic done;

	assign done = active && iBusIn.ack;
	assign fetchWait = active && !iBusIn.ack;

	always_comb begin
		iBusOut.cyc = active;
		iBusOut.stb = active; // Request stays open until ack
		iBusOut.we = 1'b0;
		iBusOut.adr = pc;
		iBusOut.datW = '0;
		iBusOut.sel = 4'hf;
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			active <= 1'b0;
			pc <= mipsPkg::RESET_PC;
		end else begin
			active <= 1'b1;
			if (done && pcWr)
				pc <= branchTaken ? branchTarget : pc + 32'd4; // Target lands after delay slot
		end
	end

	// A word acked while the front end is held is dropped and fetched again
	always_ff @(posedge clk) begin
		if (rst_sign) begin
			ifId <= '0;
		end else if (done && ifIdWr) begin
			ifId.valid <= 1'b1;
			ifId.pc <= pc;
			ifId.instr <= iBusIn.datR;
		end
	end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
	input wire clk,
	input wire rst_sign,
	input wire [4:0] rdIdxA,
	input wire [4:0] rdIdxB,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB,
	input wire mipsPkg::memWbReg wb
);

	logic [31:0] regs [32];
	logic wrEn;

	assign wrEn = wb.regWrite && (wb.dest != 5'd0) && !rst_sign;

	always_ff @(posedge clk) begin
		if (wrEn)
			regs[wb.dest] <= wb.wrData;
	end

	always_comb begin
		if (rdIdxA == 5'd0)
			rdDataA = '0; // r0 is hardwired
		else if (wrEn && (wb.dest == rdIdxA))
			rdDataA = wb.wrData; // Write-through covers WB distance
		else
			rdDataA = regs[rdIdxA];
	end

	always_comb begin
		if (rdIdxB == 5'd0)
			rdDataB = '0;
		else if (wrEn && (wb.dest == rdIdxB))
			rdDataB = wb.wrData;
		else
			rdDataB = regs[rdIdxB];
	end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`default_nettype none

module decodeStage (
	input wire clk,
	input wire rst_sign,
	input wire mipsPkg::ifIdReg ifId,
	input wire idExWr,
	input wire bubble,
	input wire fwdBrA,
	input wire fwdBrB,
	input wire [31:0] memFwdData,
	input wire mipsPkg::memWbReg wb,
	output mipsPkg::idExReg idEx,
	output logic branchTaken,
	output logic [31:0] branchTarget,
	output logic isBranch,
	output logic [4:0] idRs,
	output logic [4:0] idRt
);

	mipsPkg::instrWord ins;
	mipsPkg::idExReg dec;
	logic [5:0] op;
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] brA;
	logic [31:0] brB;
	logic [31:0] immSext;

	assign ins = ifId.instr;
	assign op = ins.iFields.op;
	assign idRs = ins.rFields.rs;
	assign idRt = ins.iFields.rt;
	assign immSext = {{16{ins.iFields.imm16[15]}}, ins.iFields.imm16};

	regFile regFile0 (
		.clk(clk),
		.rst_sign(rst_sign),
		.rdIdxA(idRs),
		.rdIdxB(idRt),
		.rdDataA(regA),
		.rdDataB(regB),
		.wb(wb)
	);

	assign brA = fwdBrA ? memFwdData : regA; // MEM bypass for compare
	assign brB = fwdBrB ? memFwdData : regB;
	assign isBranch = ifId.valid && ((op == mipsPkg::OP_BEQ) || (op == mipsPkg::OP_BNE));
	assign branchTaken = isBranch && ((op == mipsPkg::OP_BEQ) == (brA == brB));
	assign branchTarget = ifId.pc + 32'd4 + {immSext[29:0], 2'b00};

	always_comb begin
		dec = '0;
		dec.pc = ifId.pc;
		dec.rs = idRs;
		dec.rt = idRt;
		dec.opA = regA;
		dec.opB = regB;
		dec.imm = immSext;
		dec.alu = mipsPkg::aluAdd;
		if (ifId.valid) begin
			case (op)
				mipsPkg::OP_RTYPE: begin
					dec.dest = ins.rFields.rd;
					dec.regWrite = 1'b1;
					case (ins.rFields.funct)
						mipsPkg::FN_ADDU: dec.alu = mipsPkg::aluAdd;
						mipsPkg::FN_SUBU: dec.alu = mipsPkg::aluSub;
						mipsPkg::FN_AND: dec.alu = mipsPkg::aluAnd;
						mipsPkg::FN_OR: dec.alu = mipsPkg::aluOr;
						mipsPkg::FN_SLT: dec.alu = mipsPkg::aluSlt;
						default: dec.regWrite = 1'b0; // Unsupported funct acts as NOP
					endcase
				end
				mipsPkg::OP_ADDIU: begin
					dec.dest = idRt;
					dec.aluSrcImm = 1'b1;
					dec.regWrite = 1'b1;
				end
				mipsPkg::OP_ORI: begin
					dec.dest = idRt;
					dec.imm = {16'h0000, ins.iFields.imm16}; // Zero extend
					dec.alu = mipsPkg::aluOr;
					dec.aluSrcImm = 1'b1;
					dec.regWrite = 1'b1;
				end
				mipsPkg::OP_LUI: begin
					dec.dest = idRt;
					dec.imm = {ins.iFields.imm16, 16'h0000}; // rs is r0 so add passes it
					dec.aluSrcImm = 1'b1;
					dec.regWrite = 1'b1;
				end
				mipsPkg::OP_LW: begin
					dec.dest = idRt;
					dec.aluSrcImm = 1'b1;
					dec.memRead = 1'b1;
					dec.regWrite = 1'b1;
				end
				mipsPkg::OP_SW: begin
					dec.aluSrcImm = 1'b1;
					dec.memWrite = 1'b1;
				end
				default: ; // Branches finish here in ID
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sign)
			idEx <= '0;
		else if (idExWr)
			idEx <= bubble ? '0 : dec;
	end

endmodule

`default_nettype wire

// ==== forwardUnit.sv ====
`default_nettype none

module forwardUnit (
	input wire [4:0] exRs,
	input wire [4:0] exRt,
	input wire [4:0] idRs,
	input wire [4:0] idRt,
	input wire mipsPkg::exMemReg exMem,
	input wire mipsPkg::memWbReg memWb,
	input wire isBranch,
	output mipsPkg::fwdSel fwdA,
	output mipsPkg::fwdSel fwdB,
	output logic fwdBrA,
	output logic fwdBrB
);

	function automatic mipsPkg::fwdSel pickEx(input logic [4:0] src,
			input mipsPkg::exMemReg m, input mipsPkg::memWbReg w);
		if (m.regWrite && (m.dest != 5'd0) && (m.dest == src))
			return mipsPkg::fromMem; // Newest value wins
		else if (w.regWrite && (w.dest != 5'd0) && (w.dest == src))
			return mipsPkg::fromWb;
		else
			return mipsPkg::none;
	endfunction

	function automatic logic pickBr(input logic [4:0] src, input logic br,
			input mipsPkg::exMemReg m);
		// hazardUnit stalls while load data is still in MEM
		return br && m.regWrite && !m.memRead && (m.dest != 5'd0) && (m.dest == src);
	endfunction

	assign fwdA = pickEx(exRs, exMem, memWb);
	assign fwdB = pickEx(exRt, exMem, memWb);
	assign fwdBrA = pickBr(idRs, isBranch, exMem);
	assign fwdBrB = pickBr(idRt, isBranch, exMem);

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`default_nettype none

module hazardUnit (
	input wire rst_sign,
	input wire fetchWait,
	input wire dataWait,
	input wire isBranch,
	input wire [4:0] idRs,
	input wire [4:0] idRt,
	input wire mipsPkg::idExReg idEx,
	input wire mipsPkg::exMemReg exMem,
	output logic pcWr,
	output logic ifIdWr,
	output logic idExWr,
	output logic exMemWr,
	output logic memWbWr,
	output logic bubble
);

	logic busFreeze;
	logic loadUse;
	logic brLoadMem;
	logic brExWrite;

	assign busFreeze = fetchWait || dataWait; // Any open bus cycle holds everything
	assign loadUse = idEx.memRead && ((idEx.rt == idRs) || (idEx.rt == idRt));
	assign brLoadMem = isBranch && exMem.memRead && exMem.regWrite
		&& ((exMem.dest == idRs) || (exMem.dest == idRt));
	assign brExWrite = isBranch && idEx.regWrite && (idEx.dest != 5'd0)
		&& ((idEx.dest == idRs) || (idEx.dest == idRt));

	always_comb begin
		pcWr = 1'b0;
		ifIdWr = 1'b0;
		idExWr = 1'b0;
		exMemWr = 1'b0;
		memWbWr = 1'b0;
		bubble = 1'b0;
		if (rst_sign || busFreeze) begin
			bubble = 1'b0; // Nothing moves on reset or freeze
		end else if (loadUse || brLoadMem || brExWrite) begin
			idExWr = 1'b1; // Front held while a bubble goes down the pipe
			exMemWr = 1'b1;
			memWbWr = 1'b1;
			bubble = 1'b1;
		end else begin
			pcWr = 1'b1;
			ifIdWr = 1'b1;
			idExWr = 1'b1;
			exMemWr = 1'b1;
			memWbWr = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== execMemStage.sv ====
`default_nettype none

module execMemStage (
	input wire clk,
	input wire rst_sign,
	input wire mipsPkg::idExReg idEx,
	input wire mipsPkg::fwdSel fwdA,
	input wire mipsPkg::fwdSel fwdB,
	input wire exMemWr,
	input wire memWbWr,
	output mipsPkg::wbMaster dBusOut,
	input wire mipsPkg::wbSlave dBusIn,
	output mipsPkg::exMemReg exMem,
	output mipsPkg::memWbReg memWb,
	output logic dataWait,
	output mipsPkg::retireInfo retire
);

	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluB;
	logic [31:0] aluRes;
	logic memReq;
	logic dAckSeen; // Data transfer already done while frozen
	logic [31:0] loadHold;
	logic [31:0] loadData;
	logic wbDone; // WB entry already reported

	function automatic logic [31:0] pickOp(input mipsPkg::fwdSel sel,
			input logic [31:0] base, input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			mipsPkg::fromMem: return memVal;
			mipsPkg::fromWb: return wbVal;
			default: return base;
		endcase
	endfunction

	assign srcA = pickOp(fwdA, idEx.opA, exMem.aluRes, memWb.wrData);
	assign srcB = pickOp(fwdB, idEx.opB, exMem.aluRes, memWb.wrData);
	assign aluB = idEx.aluSrcImm ? idEx.imm : srcB;

	always_comb begin
		case (idEx.alu)
			mipsPkg::aluSub: aluRes = srcA - aluB;
			mipsPkg::aluAnd: aluRes = srcA & aluB;
			mipsPkg::aluOr: aluRes = srcA | aluB;
			mipsPkg::aluSlt: aluRes = {31'd0, $signed(srcA) < $signed(aluB)};
			default: aluRes = srcA + aluB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			exMem <= '0;
		end else if (exMemWr) begin
			exMem.dest <= idEx.dest;
			exMem.aluRes <= aluRes;
			exMem.storeData <= srcB; // Forwarded rt
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.regWrite <= idEx.regWrite;
		end
	end

	assign memReq = (exMem.memRead || exMem.memWrite) && !dAckSeen;
	assign dataWait = memReq && !dBusIn.ack;
	assign loadData = dAckSeen ? loadHold : dBusIn.datR;

	always_comb begin
		dBusOut.cyc = memReq;
		dBusOut.stb = memReq;
		dBusOut.we = exMem.memWrite;
		dBusOut.adr = exMem.aluRes;
		dBusOut.datW = exMem.storeData;
		dBusOut.sel = 4'hf; // Word access only
	end

	// Keeps a store from being issued twice when fetch holds the pipe
	always_ff @(posedge clk) begin
		if (rst_sign || memWbWr)
			dAckSeen <= 1'b0;
		else if (memReq && dBusIn.ack)
			dAckSeen <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (memReq && dBusIn.ack)
			loadHold <= dBusIn.datR;
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			memWb <= '0;
		end else if (memWbWr) begin
			memWb.dest <= exMem.dest;
			memWb.wrData <= exMem.memRead ? loadData : exMem.aluRes;
			memWb.regWrite <= exMem.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sign)
			wbDone <= 1'b0;
		else
			wbDone <= !memWbWr; // Held MEM/WB is not a new retire
	end

	assign retire.valid = memWb.regWrite && (memWb.dest != 5'd0) && !wbDone;
	assign retire.idx = memWb.dest;
	assign retire.data = memWb.wrData;

endmodule

`default_nettype wire

// ==== pipelineCore.sv ====
`default_nettype none

module pipelineCore (
	input wire clk,
	input wire rst_sign,
	output mipsPkg::wbMaster iBusOut,
	input wire mipsPkg::wbSlave iBusIn,
	output mipsPkg::wbMaster dBusOut,
	input wire mipsPkg::wbSlave dBusIn,
	output mipsPkg::retireInfo retire
);

	mipsPkg::ifIdReg ifId;
	mipsPkg::idExReg idEx;
	mipsPkg::exMemReg exMem;
	mipsPkg::memWbReg memWb;
	mipsPkg::fwdSel fwdA;
	mipsPkg::fwdSel fwdB;
	logic pcWr;
	logic ifIdWr;
	logic idExWr;
	logic exMemWr;
	logic memWbWr;
	logic bubble;
	logic fetchWait;
	logic dataWait;
	logic branchTaken;
	logic [31:0] branchTarget;
	logic isBranch;
	logic [4:0] idRs;
	logic [4:0] idRt;
	logic fwdBrA;
	logic fwdBrB;

	fetchUnit fetch0 (
		.clk(clk), .rst_sign(rst_sign), .pcWr(pcWr), .ifIdWr(ifIdWr),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.iBusOut(iBusOut), .iBusIn(iBusIn), .ifId(ifId), .fetchWait(fetchWait)
	);

	decodeStage decode0 (
		.clk(clk), .rst_sign(rst_sign), .ifId(ifId), .idExWr(idExWr), .bubble(bubble),
		.fwdBrA(fwdBrA), .fwdBrB(fwdBrB), .memFwdData(exMem.aluRes), .wb(memWb),
		.idEx(idEx), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.isBranch(isBranch), .idRs(idRs), .idRt(idRt)
	);

	forwardUnit forward0 (
		.exRs(idEx.rs), .exRt(idEx.rt), .idRs(idRs), .idRt(idRt),
		.exMem(exMem), .memWb(memWb), .isBranch(isBranch),
		.fwdA(fwdA), .fwdB(fwdB), .fwdBrA(fwdBrA), .fwdBrB(fwdBrB)
	);

	hazardUnit hazard0 (
		.rst_sign(rst_sign), .fetchWait(fetchWait), .dataWait(dataWait),
		.isBranch(isBranch), .idRs(idRs), .idRt(idRt), .idEx(idEx), .exMem(exMem),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .idExWr(idExWr), .exMemWr(exMemWr),
		.memWbWr(memWbWr), .bubble(bubble)
	);

	execMemStage execMem0 (
		.clk(clk), .rst_sign(rst_sign), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
		.exMemWr(exMemWr), .memWbWr(memWbWr), .dBusOut(dBusOut), .dBusIn(dBusIn),
		.exMem(exMem), .memWb(memWb), .dataWait(dataWait), .retire(retire)
	);

endmodule

`default_nettype wire

// ==== clockGen.sv ====
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst_sign
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // Period 20
	end

	initial begin
		rst_sign = 1'b1;
		repeat (5) @(posedge clk);
		#2 rst_sign = 1'b0; // Released just after the fifth edge
	end

endmodule

`default_nettype wire

// ==== coreTb.sv ====
`default_nettype none

module coreTb;

	localparam logic [31:0] HALT_ADR = 32'd140; // Word 35, branch to itself

	logic clk;
	logic rst_sign;
	mipsPkg::wbMaster iBusOut;
	mipsPkg::wbSlave iBusIn = '0;
	mipsPkg::wbMaster dBusOut;
	mipsPkg::wbSlave dBusIn = '0;
	mipsPkg::retireInfo retireOut;

	logic [31:0] rom [256];
	logic [31:0] ram [256];
	mipsPkg::retireInfo expRet [$];
	mipsPkg::wbMaster expStore [$];
	int seed = 38;
	int iWait = -1;
	int dWait = -1;
	int progLen = 0;
	int errors = 0;
	int retCount = 0;
	int storeCount = 0;
	bit fetchSeen = 1'b0;
	bit timedOut = 1'b0;

	clockGen clockGen0 (.clk(clk), .rst_sign(rst_sign));

	pipelineCore dut0 (
		.clk(clk), .rst_sign(rst_sign), .iBusOut(iBusOut), .iBusIn(iBusIn),
		.dBusOut(dBusOut), .dBusIn(dBusIn), .retire(retireOut)
	);

	function automatic logic [31:0] fillWord(input logic [31:0] byteAdr);
		return (byteAdr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
	endfunction

	function automatic mipsPkg::instrWord rIns(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		mipsPkg::instrWord w;
		w = '0;
		w.rFields.op = mipsPkg::OP_RTYPE;
		w.rFields.rs = rs;
		w.rFields.rt = rt;
		w.rFields.rd = rd;
		w.rFields.funct = fn;
		return w;
	endfunction

	function automatic mipsPkg::instrWord iIns(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		mipsPkg::instrWord w;
		w.iFields.op = op;
		w.iFields.rs = rs;
		w.iFields.rt = rt;
		w.iFields.imm16 = imm;
		return w;
	endfunction

	task automatic putWord(input mipsPkg::instrWord w);
		rom[progLen] = w;
		progLen++;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < 256; i++) begin
			rom[i] = '0; // NOP everywhere else
			ram[i] = fillWord(i * 4);
		end
		putWord(iIns(mipsPkg::OP_LUI, 1, 0, 16'h1234));
		putWord(iIns(mipsPkg::OP_ORI, 1, 1, 16'h5678)); // Distance 1
		putWord(iIns(mipsPkg::OP_ADDIU, 2, 0, 16'd100));
		putWord(iIns(mipsPkg::OP_ADDIU, 3, 0, 16'hfff9));
		putWord(rIns(mipsPkg::FN_ADDU, 4, 2, 3)); // Distances 2 and 1
		putWord(rIns(mipsPkg::FN_SUBU, 5, 4, 2));
		putWord(rIns(mipsPkg::FN_AND, 6, 1, 5));
		putWord(rIns(mipsPkg::FN_OR, 7, 6, 4));
		putWord(rIns(mipsPkg::FN_SLT, 8, 3, 2));
		putWord(iIns(mipsPkg::OP_ADDIU, 0, 0, 16'd55)); // r0 must stay zero
		putWord(rIns(mipsPkg::FN_ADDU, 10, 0, 8));
		putWord(iIns(mipsPkg::OP_SW, 1, 0, 16'd16));
		putWord(iIns(mipsPkg::OP_LW, 9, 0, 16'd16));
		putWord(rIns(mipsPkg::FN_ADDU, 11, 9, 2)); // Load-use
		putWord(iIns(mipsPkg::OP_LW, 12, 0, 16'd20));
		putWord(iIns(mipsPkg::OP_ADDIU, 13, 0, 16'd3));
		putWord(iIns(mipsPkg::OP_BNE, 13, 12, 16'd2)); // Load two ahead and ALU just before
		putWord(iIns(mipsPkg::OP_ADDIU, 14, 0, 16'd1)); // Delay slot
		putWord(iIns(mipsPkg::OP_ADDIU, 14, 0, 16'd2));
		putWord(iIns(mipsPkg::OP_ADDIU, 15, 13, 16'hfffd));
		putWord(iIns(mipsPkg::OP_BEQ, 0, 15, 16'd2));
		putWord(iIns(mipsPkg::OP_ADDIU, 16, 0, 16'd9));
		putWord(iIns(mipsPkg::OP_ADDIU, 16, 0, 16'd10));
		putWord(iIns(mipsPkg::OP_ADDIU, 17, 0, 16'd4));
		putWord(iIns(mipsPkg::OP_BEQ, 0, 17, 16'd5)); // Not taken
		putWord(iIns(mipsPkg::OP_ADDIU, 18, 0, 16'd6));
		putWord(iIns(mipsPkg::OP_BNE, 18, 18, 16'd5));
		putWord('0);
		putWord(iIns(mipsPkg::OP_LW, 19, 0, 16'd8));
		putWord(rIns(mipsPkg::FN_ADDU, 20, 0, 0));
		putWord(iIns(mipsPkg::OP_BEQ, 19, 19, 16'd2));
		putWord(iIns(mipsPkg::OP_SW, 20, 0, 16'd24)); // Store in delay slot
		putWord(iIns(mipsPkg::OP_ADDIU, 21, 0, 16'd77));
		putWord(iIns(mipsPkg::OP_SW, 7, 0, 16'd28));
		putWord(iIns(mipsPkg::OP_ADDIU, 22, 20, 16'd2));
		putWord(iIns(mipsPkg::OP_BEQ, 0, 0, 16'hffff)); // Halt loop
		putWord('0);
	endtask

	// ISA-level model with one delay slot
	function automatic void runModel();
		logic [31:0] mRegs [32];
		logic [31:0] mRam [256];
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] newNext;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sImm;
		logic [31:0] res;
		logic [4:0] dst;
		logic wr;
		mipsPkg::instrWord w;
		mipsPkg::retireInfo r;
		mipsPkg::wbMaster s;
		int steps;
		for (int i = 0; i < 32; i++)
			mRegs[i] = '0;
		for (int i = 0; i < 256; i++)
			mRam[i] = fillWord(i * 4);
		pc = mipsPkg::RESET_PC;
		nextPc = pc + 32'd4;
		steps = 0;
		while (steps < 500 && pc != HALT_ADR) begin
			w = rom[pc[9:2]];
			a = mRegs[w.rFields.rs];
			b = mRegs[w.rFields.rt];
			sImm = {{16{w.iFields.imm16[15]}}, w.iFields.imm16};
			newNext = nextPc + 32'd4;
			dst = w.iFields.rt;
			wr = 1'b1;
			res = '0;
			case (w.iFields.op)
				mipsPkg::OP_RTYPE: begin
					dst = w.rFields.rd;
					case (w.rFields.funct)
						mipsPkg::FN_ADDU: res = a + b;
						mipsPkg::FN_SUBU: res = a - b;
						mipsPkg::FN_AND: res = a & b;
						mipsPkg::FN_OR: res = a | b;
						mipsPkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				mipsPkg::OP_ADDIU: res = a + sImm;
				mipsPkg::OP_ORI: res = a | {16'h0000, w.iFields.imm16};
				mipsPkg::OP_LUI: res = {w.iFields.imm16, 16'h0000};
				mipsPkg::OP_LW: res = mRam[(a + sImm) >> 2 & 32'hff];
				mipsPkg::OP_SW: begin
					wr = 1'b0;
					mRam[(a + sImm) >> 2 & 32'hff] = b;
					s = '0;
					s.cyc = 1'b1;
					s.stb = 1'b1;
					s.we = 1'b1;
					s.adr = a + sImm;
					s.datW = b;
					s.sel = 4'hf;
					expStore.push_back(s);
				end
				mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
					wr = 1'b0;
					if ((a == b) == (w.iFields.op == mipsPkg::OP_BEQ))
						newNext = pc + 32'd4 + {sImm[29:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				mRegs[dst] = res;
				r.valid = 1'b1;
				r.idx = dst;
				r.data = res;
				expRet.push_back(r);
			end
			pc = nextPc;
			nextPc = newNext;
			steps++;
		end
	endfunction

	task automatic checkRetire(input mipsPkg::retireInfo got, input mipsPkg::retireInfo exp);
		retCount++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: retire r%0d=%h, expected r%0d=%h",
				$time, got.idx, got.data, exp.idx, exp.data);
		end
	endtask

	task automatic checkStore(input mipsPkg::wbMaster got, input mipsPkg::wbMaster exp);
		storeCount++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: store %h to %h sel %h, expected %h to %h",
				$time, got.datW, got.adr, got.sel, exp.datW, exp.adr);
		end
	endtask

	// Both slaves in one block so the random draws keep a fixed order
	always @(posedge clk) begin
		#2;
		if (rst_sign) begin
			iBusIn = '0;
			dBusIn = '0;
			iWait = -1;
			dWait = -1;
		end else begin
			if (iBusIn.ack) begin
				iBusIn.ack = 1'b0; // Transfer ended at this edge
				iWait = -1;
			end
			if (iBusOut.cyc && iBusOut.stb) begin
				if (iWait < 0)
					iWait = $unsigned($random(seed)) % 4;
				if (iWait == 0) begin
					iBusIn.ack = 1'b1;
					iBusIn.datR = rom[iBusOut.adr[9:2]];
				end else
					iWait--;
			end else
				iWait = -1;
			if (dBusIn.ack) begin
				dBusIn.ack = 1'b0;
				dWait = -1;
			end
			if (dBusOut.cyc && dBusOut.stb) begin
				if (dWait < 0)
					dWait = $unsigned($random(seed)) % 4;
				if (dWait == 0) begin
					dBusIn.ack = 1'b1;
					dBusIn.datR = ram[dBusOut.adr[9:2]];
					if (dBusOut.we)
						ram[dBusOut.adr[9:2]] = dBusOut.datW;
				end else
					dWait--;
			end else
				dWait = -1;
		end
	end

	// Compare process samples mid-cycle
	always @(negedge clk) begin
		if (rst_sign) begin
			if (iBusOut.cyc || iBusOut.stb || dBusOut.cyc || dBusOut.stb
					|| retireOut.valid) begin
				errors++;
				$display("Bus cycle or retire seen while reset is held at %0t", $time);
			end
		end else begin
			if (!fetchSeen && iBusOut.stb)
				fetchSeen = 1'b1;
			else if (!fetchSeen && (retireOut.valid || dBusOut.cyc || dBusOut.stb)) begin
				errors++;
				$display("Activity before the first fetch request at %0t", $time);
			end
			if (retireOut.valid) begin
				if (expRet.size() == 0) begin
					errors++;
					$display("Unexpected write of r%0d at %0t", retireOut.idx, $time);
				end else
					checkRetire(retireOut, expRet.pop_front());
			end
			if (dBusOut.stb && dBusOut.we && dBusIn.ack) begin
				if (expStore.size() == 0) begin
					errors++;
					$display("Unexpected store to %h at %0t", dBusOut.adr, $time);
				end else
					checkStore(dBusOut, expStore.pop_front());
			end
		end
	end

	initial begin
		int cycles;
		loadProgram();
		runModel();
		cycles = 0;
		while (rst_sign !== 1'b0 && cycles < 50) begin
			@(posedge clk);
			cycles++;
		end
		if (rst_sign !== 1'b0) begin
			timedOut = 1'b1;
			$display("Reset was never released");
		end
		cycles = 0;
		while (!timedOut && (expRet.size() > 0 || expStore.size() > 0) && cycles < 3000) begin
			@(negedge clk);
			cycles++;
		end
		if (expRet.size() > 0 || expStore.size() > 0) begin
			timedOut = 1'b1;
			$display("Timed out with %0d writes and %0d stores still missing",
				expRet.size(), expStore.size());
		end
		cycles = 0;
		while (!timedOut && cycles < 20) begin // Catch extra retires in the halt loop
			@(negedge clk);
			cycles++;
		end
		$display("Retire checks %0d, store checks %0d, errors %0d", retCount, storeCount, errors);
		if (errors == 0 && !timedOut)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
mipsPkg.sv
fetchUnit.sv
regFile.sv
decodeStage.sv
forwardUnit.sv
hazardUnit.sv
execMemStage.sv
pipelineCore.sv
clockGen.sv
coreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module coreTb -o coreTbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/coreTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	exit 1
fi
exit 0
